/* list.f */
+incdir+src
src/core_pkg.sv
src/ifetch.sv
src/decode.sv
src/exec.sv
src/int_regfile.sv
src/bus_arbiter.sv
src/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module core_tb \
    -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -q "TB PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* testbench/core_tb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb import core_pkg::*; ();

    localparam int PROG_LEN = 60;
    localparam int DATA_BASE = 256;  // Word index of byte address 0x400
    localparam int TIMEOUT = 300;

    logic             clk, rst;
    logic             mem_req_valid, mem_req_ready, mem_rsp_valid;
    mem_req_t         mem_req;
    mem_rsp_t         mem_rsp;
    logic [4:0]       reg_read_sel;
    logic [`XLEN-1:0] reg_read_data;
    logic             retire_valid;
    retire_t          retire;

    logic [31:0] mem [512];
    logic [31:0] ref_mem [512];
    int          p_kind [PROG_LEN+1];
    logic [4:0]  p_rd [PROG_LEN+1], p_rs1 [PROG_LEN+1], p_rs2 [PROG_LEN+1];
    logic [31:0] p_imm [PROG_LEN+1];
    logic [31:0] ref_regs [32];
    retire_t     exp_q [$];
    int          checks, errors, seed_val;
    logic        mem_enable, pending, timed_out;
    int          delay;
    mem_req_t    held_req;

    core_top u_core_top (.*);

    bind core_top core_chk u_core_chk (
        .clk(clk), .rst(rst), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req(mem_req), .mem_rsp_valid(mem_rsp_valid), .retire_valid(retire_valid),
        .rf_busy(rf_busy), .dec_valid(dec_valid), .dec_ready(dec_ready),
        .redirect_valid(redirect_valid), .dec_pkt(dec_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory with random ready stalls and a 1 to 3 cycle response delay
    always begin
        logic     accepted;
        logic     in_reset;
        mem_req_t req_now;
        @(posedge clk);
        accepted = mem_req_valid && mem_req_ready;
        in_reset = rst;
        req_now = mem_req;
        #1;
        mem_rsp_valid = 1'b0;
        if (in_reset) begin
            pending = 1'b0;  // A reset abandons the request in flight
        end else if (pending) begin
            delay = delay - 1;
            if (delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp = '{rdata: mem[held_req.addr[10:2]]};
                if (held_req.we)
                    mem[held_req.addr[10:2]] = held_req.wdata;
                pending = 1'b0;
            end
        end
        if (accepted && !in_reset) begin
            held_req = req_now;
            pending = 1'b1;
            delay = $urandom_range(1, 3);
        end
        mem_req_ready = mem_enable && !pending && ($urandom_range(0, 3) != 0);
    end

    task automatic build_program();
        logic [31:0] r, word;
        int          off;
        for (int i = 0; i < 512; i++)
            mem[i] = 32'(i) * 32'h9e37_79b9 + 32'h5a5a_0000;
        for (int i = 0; i <= PROG_LEN; i++) begin
            p_kind[i] = $urandom_range(0, 7);
            p_rd[i] = 5'($urandom_range(0, 7));
            p_rs1[i] = 5'($urandom_range(0, 7));
            p_rs2[i] = 5'($urandom_range(0, 7));
            r = $urandom;
            if (i == PROG_LEN) begin  // Halt is BEQ x0,x0,0
                p_kind[i] = 6;
                p_rs1[i] = 5'd0;
                p_rs2[i] = 5'd0;
            end
            case (p_kind[i])
                2: p_imm[i] = {{20{r[11]}}, r[11:0]};
                3: p_imm[i] = {r[19:0], 12'b0};
                4, 5: begin
                    p_rs1[i] = 5'd0;  // Absolute address inside the data region
                    p_imm[i] = 32'h400 + 32'(4 * $urandom_range(0, 63));
                end
                6, 7: begin
                    off = $urandom_range(1, 3);
                    if (i + off > PROG_LEN)
                        off = PROG_LEN - i;
                    p_imm[i] = 32'(off * 4);
                end
                default: p_imm[i] = '0;
            endcase
            case (p_kind[i])
                0: word = {7'b0, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
                1: word = {7'b0100000, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
                2: word = {p_imm[i][11:0], p_rs1[i], 3'b000, p_rd[i], 7'b0010011};
                3: word = {p_imm[i][31:12], p_rd[i], 7'b0110111};
                4: word = {p_imm[i][11:0], p_rs1[i], 3'b010, p_rd[i], 7'b0000011};
                5: word = {p_imm[i][11:5], p_rs2[i], p_rs1[i], 3'b010, p_imm[i][4:0],
                           7'b0100011};
                default: word = {p_imm[i][12], p_imm[i][10:5], p_rs2[i], p_rs1[i],
                                 (p_kind[i] == 7) ? 3'b001 : 3'b000, p_imm[i][4:1],
                                 p_imm[i][11], 7'b1100011};
            endcase
            mem[i] = word;
        end
        for (int i = 0; i < 512; i++)
            ref_mem[i] = mem[i];
    endtask

    // Sequential ISA execution up to and including the first halt retire
    task automatic run_model();
        int          idx, next;
        logic [31:0] a, b, val, addr;
        retire_t     e;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        idx = 0;
        while (idx <= PROG_LEN) begin
            a = ref_regs[p_rs1[idx]];
            b = ref_regs[p_rs2[idx]];
            addr = a + p_imm[idx];
            next = idx + 1;
            val = '0;
            case (p_kind[idx])
                0: val = a + b;
                1: val = a - b;
                2: val = a + p_imm[idx];
                3: val = p_imm[idx];
                4: val = ref_mem[addr[10:2]];
                5: ref_mem[addr[10:2]] = b;
                6: if (a == b) next = idx + int'(p_imm[idx]) / 4;
                default: if (a != b) next = idx + int'(p_imm[idx]) / 4;
            endcase
            e = '{pc: `RESET_PC + 32'(idx * 4), rd: p_rd[idx], we: 1'b0, wdata: '0};
            if (p_kind[idx] <= 4 && p_rd[idx] != 5'd0) begin  // x0 writes are dropped
                ref_regs[p_rd[idx]] = val;
                e.we = 1'b1;
                e.wdata = val;
            end
            exp_q.push_back(e);
            if (idx == PROG_LEN)
                break;
            idx = next;
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        checks++;
        if (got.pc !== exp.pc || got.we !== exp.we ||
            (exp.we && (got.rd !== exp.rd || got.wdata !== exp.wdata))) begin
            errors++;
            $display("[ERROR] %0t retire pc=%h rd=%0d we=%b data=%h, expected %h %0d %b %h",
                     $time, got.pc, got.rd, got.we, got.wdata,
                     exp.pc, exp.rd, exp.we, exp.wdata);
        end
    endtask

    task automatic check_reg(input int idx, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t x%0d reads %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_mem(input int addr, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t memory at %h holds %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic read_reg(input int idx, output logic [`XLEN-1:0] val);
        @(posedge clk);
        #1 reg_read_sel = 5'(idx);
        @(negedge clk);
        val = reg_read_data;
    endtask

    task automatic wait_retire(output retire_t got);
        int n;
        n = 0;
        got = '0;
        @(negedge clk);
        while (!retire_valid && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (retire_valid) begin
            got = retire;
        end else begin
            timed_out = 1'b1;
            $display("Timeout: the core retired nothing for %0d cycles", TIMEOUT);
        end
    endtask

    initial begin
        logic [`XLEN-1:0] val;
        retire_t          got;
        int               start;
        rst = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        reg_read_sel = '0;
        mem_enable = 1'b1;  // Open during the clearing, when fetch must still stay off the bus
        pending = 1'b0;
        timed_out = 1'b0;
        delay = 0;
        checks = 0;
        errors = 0;
        seed_val = $urandom(32'h1eed);
        build_program();
        run_model();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        start = errors;
        for (int i = 0; i < exp_q.size() && !timed_out; i++) begin
            wait_retire(got);
            if (!timed_out)
                check_retire(got, exp_q[i]);
        end
        $display("Test retire trace of %0d instructions: %0d errors", exp_q.size(),
                 errors - start);

        start = errors;
        for (int i = 1; i < 32; i++) begin
            read_reg(i, val);
            check_reg(i, val, ref_regs[i]);
        end
        $display("Test final registers: %0d errors", errors - start);

        start = errors;
        for (int i = DATA_BASE; i < DATA_BASE + 64; i++)
            check_mem(i * 4, mem[i], ref_mem[i]);
        $display("Test data region: %0d errors", errors - start);

        // Second reset with the memory closed, so the core stays idle while the
        // registers written by the program are read back cleared
        start = errors;
        @(posedge clk);
        #1 mem_enable = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        repeat (`NUM_REGS + 4) @(posedge clk);
        for (int i = 1; i < 32; i++) begin
            read_reg(i, val);
            check_reg(i, val, '0);
        end
        $display("Test reset clear: %0d errors", errors - start);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* testbench/core_chk.sv */
`timescale 1ns/1ps

module core_chk import core_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        mem_req_valid,
    input logic        mem_req_ready,
    input mem_req_t    mem_req,
    input logic        mem_rsp_valid,
    input logic        retire_valid,
    input logic        rf_busy,
    input logic        dec_valid,
    input logic        dec_ready,
    input logic        redirect_valid,
    input decode_pkt_t dec_pkt
);

    logic pending;  // Own view of the single outstanding bus request

    always_ff @(posedge clk) begin
        if (rst)
            pending <= 1'b0;
        else if (mem_req_valid && mem_req_ready)
            pending <= 1'b1;
        else if (mem_rsp_valid)
            pending <= 1'b0;
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("Bus request changed while it was held");

    rsp_has_req: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> pending)
        else $error("Bus response without an outstanding request");

    dec_stable: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready && !redirect_valid |=> dec_valid && $stable(dec_pkt))
        else $error("Decode packet changed while exec held it off");

    no_early_retire: assert property (@(posedge clk) disable iff (rst)
        rf_busy |-> !retire_valid)
        else $error("Retire while the register file was still clearing");

endmodule

/* src/core_top.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output mem_req_t         mem_req,
    input  logic             mem_rsp_valid,
    input  mem_rsp_t         mem_rsp,
    input  logic [4:0]       reg_read_sel,
    output logic [`XLEN-1:0] reg_read_data,
    output logic             retire_valid,
    output retire_t          retire
);

    logic             fetch_valid, fetch_ready;
    fetch_pkt_t       fetch_pkt;
    logic             dec_valid, dec_ready;
    decode_pkt_t      dec_pkt;
    logic             redirect_valid;
    logic [`ALEN-1:0] redirect_pc;
    logic [4:0]       rs1_sel, rs2_sel, wr_sel, exec_busy_rd;
    logic [`XLEN-1:0] rs1_data, rs2_data, wr_data;
    logic             wr_en, exec_busy_we, rf_busy;
    logic             f_req_valid, f_req_ready, f_rsp_valid;
    logic             d_req_valid, d_req_ready, d_rsp_valid;
    mem_req_t         f_req, d_req;
    mem_rsp_t         f_rsp, d_rsp;

    ifetch u_ifetch (
        .clk, .rst, .hold(rf_busy), .redirect_valid, .redirect_pc,
        .fetch_valid, .fetch_ready, .fetch_pkt,
        .req_valid(f_req_valid), .req_ready(f_req_ready), .req(f_req),
        .rsp_valid(f_rsp_valid), .rsp(f_rsp)
    );

    decode u_decode (
        .clk, .rst, .redirect_valid, .fetch_valid, .fetch_ready, .fetch_pkt,
        .dec_valid, .dec_ready, .dec_pkt, .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .exec_busy_rd, .exec_busy_we
    );

    exec u_exec (
        .clk, .rst, .dec_valid, .dec_ready, .dec_pkt, .redirect_valid, .redirect_pc,
        .wr_en, .wr_sel, .wr_data, .exec_busy_rd, .exec_busy_we,
        .req_valid(d_req_valid), .req_ready(d_req_ready), .req(d_req),
        .rsp_valid(d_rsp_valid), .rsp(d_rsp), .retire_valid, .retire
    );

    int_regfile u_int_regfile (
        .clk, .rst, .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .obs_sel(reg_read_sel), .obs_data(reg_read_data),
        .wr_en, .wr_sel, .wr_data, .busy(rf_busy)
    );

    bus_arbiter u_bus_arbiter (
        .clk, .rst,
        .f_req_valid, .f_req_ready, .f_req, .f_rsp_valid, .f_rsp,
        .d_req_valid, .d_req_ready, .d_req, .d_rsp_valid, .d_rsp,
        .mem_req_valid, .mem_req_ready, .mem_req, .mem_rsp_valid, .mem_rsp
    );

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     f_req_valid,
    output logic     f_req_ready,
    input  mem_req_t f_req,
    output logic     f_rsp_valid,
    output mem_rsp_t f_rsp,
    input  logic     d_req_valid,
    output logic     d_req_ready,
    input  mem_req_t d_req,
    output logic     d_rsp_valid,
    output mem_rsp_t d_rsp,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp
);

    logic outstanding;
    logic locked;        // A request is on the bus but not yet accepted
    logic owner;         // 1 for the data port
    logic grant_data;

    // Data wins a fresh grant, while a presented request keeps its slot
    assign grant_data = locked ? owner : d_req_valid;

    assign mem_req_valid = !outstanding && (f_req_valid || d_req_valid);
    assign mem_req = grant_data ? d_req : f_req;
    assign f_req_ready = !outstanding && !grant_data && mem_req_ready;
    assign d_req_ready = !outstanding && grant_data && mem_req_ready;

    assign f_rsp_valid = mem_rsp_valid && outstanding && !owner;
    assign d_rsp_valid = mem_rsp_valid && outstanding && owner;
    assign f_rsp = mem_rsp;
    assign d_rsp = mem_rsp;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
            locked <= 1'b0;
            owner <= 1'b0;
        end else if (mem_req_valid) begin
            owner <= grant_data;
            locked <= !mem_req_ready;
            outstanding <= mem_req_ready;
        end else if (mem_rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

endmodule

/* src/int_regfile.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module int_regfile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1_sel,
    input  logic [4:0]       rs2_sel,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    input  logic [4:0]       obs_sel,
    output logic [`XLEN-1:0] obs_data,
    input  logic             wr_en,
    input  logic [4:0]       wr_sel,
    input  logic [`XLEN-1:0] wr_data,
    output logic             busy
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [4:0]       clr_idx;

    // Walk from the top register down to x1, one per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_idx <= 5'(`NUM_REGS - 1);
            busy <= 1'b1;
        end else if (busy) begin
            clr_idx <= clr_idx - 5'd1;
            if (clr_idx == 5'd1)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busy)
            regs[clr_idx] <= '0;
        else if (wr_en && wr_sel != 5'd0)
            regs[wr_sel] <= wr_data;
    end

    // x0 reads as zero, and a write in flight is forwarded to every read port
    always_comb begin
        rs1_data = (rs1_sel == 5'd0) ? '0 :
                   (wr_en && wr_sel == rs1_sel) ? wr_data : regs[rs1_sel];
        rs2_data = (rs2_sel == 5'd0) ? '0 :
                   (wr_en && wr_sel == rs2_sel) ? wr_data : regs[rs2_sel];
        obs_data = (obs_sel == 5'd0) ? '0 :
                   (wr_en && wr_sel == obs_sel) ? wr_data : regs[obs_sel];
    end

endmodule

/* src/exec.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module exec import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             dec_valid,
    output logic             dec_ready,
    input  decode_pkt_t      dec_pkt,
    output logic             redirect_valid,
    output logic [`ALEN-1:0] redirect_pc,
    output logic             wr_en,
    output logic [4:0]       wr_sel,
    output logic [`XLEN-1:0] wr_data,
    output logic [4:0]       exec_busy_rd,
    output logic             exec_busy_we,
    output logic             req_valid,
    input  logic             req_ready,
    output mem_req_t         req,
    input  logic             rsp_valid,
    input  mem_rsp_t         rsp,
    output logic             retire_valid,
    output retire_t          retire
);

    exec_state_t      state;
    decode_pkt_t      pkt;         // Instruction currently owned by exec
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] alu_out;
    logic             taken;
    logic             branch_taken;
    logic             is_mem;
    logic             accept;

    assign dec_ready = (state == EX_IDLE);
    assign accept = dec_valid && dec_ready;
    assign is_mem = dec_pkt.op inside {OP_LW, OP_SW};

    always_comb begin
        case (dec_pkt.op)
            OP_ADD:  alu_out = dec_pkt.rs1_val + dec_pkt.rs2_val;
            OP_SUB:  alu_out = dec_pkt.rs1_val - dec_pkt.rs2_val;
            OP_ADDI: alu_out = dec_pkt.rs1_val + dec_pkt.imm;
            OP_LUI:  alu_out = dec_pkt.imm;
            default: alu_out = '0;
        endcase
    end

    assign branch_taken = (dec_pkt.op == OP_BEQ && dec_pkt.rs1_val == dec_pkt.rs2_val) ||
                          (dec_pkt.op == OP_BNE && dec_pkt.rs1_val != dec_pkt.rs2_val);

    assign req_valid = (state == EX_MEM_REQ);
    assign redirect_valid = (state == EX_ALU_DONE) && taken;
    assign retire_valid = (state == EX_ALU_DONE);
    assign wr_en = (state == EX_ALU_DONE) && pkt.rd_we && (pkt.rd != 5'd0);
    assign wr_sel = pkt.rd;
    assign wr_data = result;
    assign retire = '{pc: pkt.pc, rd: pkt.rd, we: wr_en, wdata: result};

    // The write in EX_ALU_DONE is seen by decode through the write-first register file
    assign exec_busy_rd = pkt.rd;
    assign exec_busy_we = pkt.rd_we && (state == EX_MEM_REQ || state == EX_MEM_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EX_IDLE;
            taken <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (accept) begin
                        state <= is_mem ? EX_MEM_REQ : EX_ALU_DONE;
                        taken <= branch_taken;
                    end
                end
                EX_MEM_REQ: begin
                    if (req_ready)
                        state <= EX_MEM_WAIT;
                end
                EX_MEM_WAIT: begin
                    if (rsp_valid)
                        state <= EX_ALU_DONE;  // Retire the cycle after the response
                end
                default: begin
                    state <= EX_IDLE;
                    taken <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt <= dec_pkt;
            result <= alu_out;
            redirect_pc <= dec_pkt.pc + dec_pkt.imm;
            req <= '{addr: dec_pkt.rs1_val + dec_pkt.imm, wdata: dec_pkt.rs2_val,
                     we: (dec_pkt.op == OP_SW)};
        end
        if (state == EX_MEM_WAIT && rsp_valid && pkt.op == OP_LW)
            result <= rsp.rdata;
    end

endmodule

/* src/decode.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decode import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  logic             fetch_valid,
    output logic             fetch_ready,
    input  fetch_pkt_t       fetch_pkt,
    output logic             dec_valid,
    input  logic             dec_ready,
    output decode_pkt_t      dec_pkt,
    output logic [4:0]       rs1_sel,
    output logic [4:0]       rs2_sel,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [4:0]       exec_busy_rd,
    input  logic             exec_busy_we
);

    logic [`ILEN-1:0] instr;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    opcode_t          op;
    logic [`XLEN-1:0] imm;
    logic             rd_we;
    logic             hazard;

    assign instr = fetch_pkt.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    always_comb begin
        op = OP_NOP;
        imm = '0;
        case (instr[6:0])
            7'b0110011: begin  // R type
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    op = OP_ADD;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    op = OP_SUB;
            end
            7'b0010011: begin  // OP-IMM
                if (funct3 == 3'b000)
                    op = OP_ADDI;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            7'b0110111: begin
                op = OP_LUI;
                imm = {instr[31:12], 12'b0};
            end
            7'b0000011: begin
                if (funct3 == 3'b010)
                    op = OP_LW;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            7'b0100011: begin
                if (funct3 == 3'b010)
                    op = OP_SW;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            7'b1100011: begin
                if (funct3 == 3'b000)
                    op = OP_BEQ;
                else if (funct3 == 3'b001)
                    op = OP_BNE;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    assign rd_we = op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LUI, OP_LW};

    // Conservative match on the raw source fields, whether or not they are used
    assign hazard = exec_busy_we && (exec_busy_rd != 5'd0) &&
                    (exec_busy_rd == rs1_sel || exec_busy_rd == rs2_sel);

    // Holding one packet at a time keeps exec's busy view complete for the hazard check
    assign fetch_ready = !dec_valid && !hazard;

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else if (redirect_valid)
            dec_valid <= 1'b0;
        else if (fetch_valid && fetch_ready)
            dec_valid <= 1'b1;
        else if (dec_valid && dec_ready)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready)
            dec_pkt <= '{op: op, rd: instr[11:7], rd_we: rd_we, rs1_val: rs1_data,
                         rs2_val: rs2_data, imm: imm, pc: fetch_pkt.pc};
    end

endmodule

/* src/ifetch.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module ifetch import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold,
    input  logic             redirect_valid,
    input  logic [`ALEN-1:0] redirect_pc,
    output logic             fetch_valid,
    input  logic             fetch_ready,
    output fetch_pkt_t       fetch_pkt,
    output logic             req_valid,
    input  logic             req_ready,
    output mem_req_t         req,
    input  logic             rsp_valid,
    input  mem_rsp_t         rsp
);

    logic [`ALEN-1:0] pc;
    logic [`ALEN-1:0] redir_pc;    // Target parked until the stale response drains
    logic             outstanding;
    logic             drop;        // Next response belongs to the old path
    logic             capture;

    // One read at a time, and only once decode has taken the held word
    assign req_valid = !hold && !fetch_valid && !outstanding;
    assign req = '{addr: pc, wdata: '0, we: 1'b0};
    assign capture = rsp_valid && outstanding && !drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
            outstanding <= 1'b0;
            drop <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready)
                outstanding <= 1'b1;
            else if (rsp_valid)
                outstanding <= 1'b0;

            if (fetch_valid && fetch_ready)
                fetch_valid <= 1'b0;

            if (rsp_valid && outstanding) begin
                if (drop) begin
                    drop <= 1'b0;
                    pc <= redir_pc;
                end else begin
                    fetch_valid <= 1'b1;
                    pc <= pc + 4;
                end
            end

            // A request already on the bus keeps its address, so its reply is dropped instead
            if (redirect_valid) begin
                fetch_valid <= 1'b0;
                if (req_valid || (outstanding && !rsp_valid))
                    drop <= 1'b1;
                else
                    pc <= redirect_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid)
            redir_pc <= redirect_pc;
        if (capture)
            fetch_pkt <= '{instr: rsp.rdata[`ILEN-1:0], pc: pc};
    end

endmodule

/* src/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    // Internal opcode after decode, anything unsupported becomes OP_NOP
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE
    } opcode_t;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_ALU_DONE,     // Result ready, retires this cycle
        EX_MEM_REQ,      // Load or store waiting for the bus to accept
        EX_MEM_WAIT      // Request accepted, waiting for the response
    } exec_state_t;

    typedef struct packed {
        logic [`ILEN-1:0] instr;
        logic [`ALEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        opcode_t          op;
        logic [4:0]       rd;
        logic             rd_we;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
        logic [`XLEN-1:0] imm;      // Already sign extended
        logic [`ALEN-1:0] pc;
    } decode_pkt_t;

    typedef struct packed {
        logic [`ALEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             we;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [`ALEN-1:0] pc;
        logic [4:0]       rd;
        logic             we;
        logic [`XLEN-1:0] wdata;
    } retire_t;

endpackage

/* src/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths
`define XLEN 32
`define ALEN 32
`define ILEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Integer register file depth, x0 included
`define NUM_REGS 32

`endif
